/* include/mem_subsys_defs.svh */
`ifndef MEM_SUBSYS_DEFS_SVH
`define MEM_SUBSYS_DEFS_SVH

// ====================
// Bus widths
// ====================

`define XLEN 32 // Data and byte address width
`define BE_W 4  // One enable per byte lane

// ====================
// Memory depths
// ====================

// Word index widths, byte size is 4 << AW
`define INST_MEM_AW 14 // 16K words of program storage
`define REGION0_AW  10 // 4 KB data region
`define REGION1_AW  14 // 64 KB data region

// ====================
// Fixed values
// ====================

`define INST_BASE_ADDR 32'h8000_0000 // Start of the fetch window
`define RV_NOP         32'h0000_0013 // addi x0, x0, 0

`endif

/* hdl/mem_subsys_pkg.sv */
`include "mem_subsys_defs.svh"

package mem_subsys_pkg;

    // Plain vectors for widths with a meaning
    typedef logic [`XLEN-1:0]        word_t;     // Data or instruction word
    typedef logic [`XLEN-1:0]        addr_t;     // Byte address
    typedef logic [`BE_W-1:0]        byte_en_t;  // Byte lane mask
    typedef logic [`INST_MEM_AW-1:0] inst_idx_t; // Instruction word index

    // Data adapter FSM
    typedef enum logic [1:0] {
        IDLE, // Waiting for a core request
        BUS,  // Wishbone cycle open
        RESP  // One-cycle ack or err pulse to the core
    } data_fsm_e;

endpackage

/* hdl/inst_fetch_adapter.sv */
`include "mem_subsys_defs.svh"

module inst_fetch_adapter
    import mem_subsys_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Core side
    input  addr_t     fetch_addr_i,  // New fetch address every cycle
    output word_t     instruction_o, // Word for the address two edges back
    // Wishbone read side
    output logic      wb_stb_o,
    output inst_idx_t wb_idx_o,
    input  logic      wb_ack_i,
    input  word_t     wb_dat_i
);

    // ====================
    // Request stage
    // ====================

    addr_t rel_addr; // Byte offset into the fetch window

    // Window offset, upper bits simply alias
    assign rel_addr = fetch_addr_i - addr_t'(`INST_BASE_ADDR);

    // Word index register, payload only
    always_ff @(posedge clk) begin
        wb_idx_o <= rel_addr[`INST_MEM_AW+1:2];
    end

    // ====================
    // Strobe and capture
    // ====================

    // Strobe stays up from the first cycle after reset
    // Every ack carries the word for the index sent one cycle earlier
    always_ff @(posedge clk) begin
        if (rst_n) begin
            wb_stb_o      <= 1'b0;
            instruction_o <= `RV_NOP; // Core sees a NOP until the pipe fills
        end else begin
            wb_stb_o <= 1'b1;
            if (wb_ack_i) begin
                instruction_o <= wb_dat_i; // Second edge of the fetch
            end
        end
    end

endmodule

/* hdl/inst_mem_3port.sv */
`include "mem_subsys_defs.svh"

module inst_mem_3port
    import mem_subsys_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Fetch port 0
    input  logic      stb0_i,
    input  inst_idx_t idx0_i,
    output logic      ack0_o,
    output word_t     dat0_o,
    // Fetch port 1
    input  logic      stb1_i,
    input  inst_idx_t idx1_i,
    output logic      ack1_o,
    output word_t     dat1_o,
    // Fetch port 2
    input  logic      stb2_i,
    input  inst_idx_t idx2_i,
    output logic      ack2_o,
    output word_t     dat2_o,
    // Program load
    input  logic      prog_we_i,
    input  inst_idx_t prog_idx_i,
    input  word_t     prog_data_i
);

    word_t mem [0:(1 << `INST_MEM_AW)-1]; // Program storage

    // Unwritten words execute as NOPs
    initial begin
        for (int i = 0; i < (1 << `INST_MEM_AW); i++) begin
            mem[i] = `RV_NOP;
        end
    end

    // ====================
    // Storage
    // ====================

    // Same-cycle fetch of a written index gets the old word
    always_ff @(posedge clk) begin
        if (prog_we_i) begin
            mem[prog_idx_i] <= prog_data_i;
        end
        dat0_o <= mem[idx0_i]; // Three reads per cycle
        dat1_o <= mem[idx1_i];
        dat2_o <= mem[idx2_i];
    end

    // One ack per strobe, never stalls
    always_ff @(posedge clk) begin
        if (rst_n) begin
            ack0_o <= 1'b0;
            ack1_o <= 1'b0;
            ack2_o <= 1'b0;
        end else begin
            ack0_o <= stb0_i;
            ack1_o <= stb1_i;
            ack2_o <= stb2_i;
        end
    end

endmodule

/* hdl/data_bus_adapter.sv */
`include "mem_subsys_defs.svh"

module data_bus_adapter
    import mem_subsys_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Core side, request held until ack or err
    input  logic     data_req_i,
    input  logic     data_we_i,
    input  addr_t    data_addr_i,
    input  byte_en_t data_be_i,
    input  word_t    data_wdata_i,
    output word_t    data_rdata_o,
    output logic     data_ack_o,
    output logic     data_err_o,
    // Wishbone master side
    output logic     wb_cyc_o,
    output logic     wb_stb_o,
    output logic     wb_we_o,
    output addr_t    wb_adr_o,
    output word_t    wb_dat_o,
    output byte_en_t wb_sel_o,
    input  logic     wb_ack_i,
    input  logic     wb_err_i,
    input  word_t    wb_dat_i
);

    data_fsm_e state_q;
    logic      bus_done; // Slave answered this cycle
    logic      take_req; // New request sampled this cycle

    assign bus_done = (state_q == BUS) && (wb_ack_i || wb_err_i);
    assign take_req = (state_q == IDLE) && data_req_i;

    // ====================
    // Control FSM
    // ====================

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q    <= IDLE;
            wb_cyc_o   <= 1'b0;
            wb_stb_o   <= 1'b0;
            data_ack_o <= 1'b0;
            data_err_o <= 1'b0;
        end else begin
            data_ack_o <= 1'b0; // Pulses last one cycle
            data_err_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (data_req_i) begin
                        state_q  <= BUS;
                        wb_cyc_o <= 1'b1; // Open exactly one bus cycle
                        wb_stb_o <= 1'b1;
                    end
                end
                BUS: begin
                    if (bus_done) begin
                        state_q    <= RESP;
                        wb_cyc_o   <= 1'b0;
                        wb_stb_o   <= 1'b0;
                        data_ack_o <= wb_ack_i;
                        data_err_o <= wb_err_i && !wb_ack_i; // Ack wins a tie
                    end
                end
                // Held request is ignored here, resampled in IDLE
                RESP:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // ====================
    // Payload
    // ====================

    always_ff @(posedge clk) begin
        if (take_req) begin
            wb_we_o  <= data_we_i; // Latch the request once
            wb_adr_o <= data_addr_i;
            wb_dat_o <= data_wdata_i;
            wb_sel_o <= data_be_i;
        end
        if (bus_done) begin
            data_rdata_o <= wb_ack_i ? wb_dat_i : '0; // Zero on error
        end
    end

endmodule

/* hdl/data_region_router.sv */
`include "mem_subsys_defs.svh"

module data_region_router
    import mem_subsys_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // From the data adapter
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  addr_t    wb_adr_i,
    input  word_t    wb_dat_i,
    input  byte_en_t wb_sel_i,
    output logic     wb_ack_o,
    output logic     wb_err_o,
    output word_t    wb_dat_o,
    // Runtime region bases, stable during a request
    input  addr_t    region0_base_i,
    input  addr_t    region1_base_i,
    // Region 0 memory
    output logic     r0_stb_o,
    output logic     r0_we_o,
    output addr_t    r0_off_o,
    output word_t    r0_dat_o,
    output byte_en_t r0_sel_o,
    input  logic     r0_ack_i,
    input  word_t    r0_dat_i,
    // Region 1 memory
    output logic     r1_stb_o,
    output logic     r1_we_o,
    output addr_t    r1_off_o,
    output word_t    r1_dat_o,
    output byte_en_t r1_sel_o,
    input  logic     r1_ack_i,
    input  word_t    r1_dat_i
);

    localparam addr_t R0_BYTES = addr_t'(1) << (`REGION0_AW + 2); // 4 KB
    localparam addr_t R1_BYTES = addr_t'(1) << (`REGION1_AW + 2); // 64 KB

    addr_t adr_w;  // Word-aligned request address
    logic  hit0;
    logic  hit1;   // Only when region 0 misses
    logic  req;    // Live strobe
    logic  err_q;

    // ====================
    // Decode
    // ====================

    assign adr_w    = {wb_adr_i[`XLEN-1:2], 2'b00};
    assign r0_off_o = adr_w - region0_base_i; // Offset below size means hit
    assign r1_off_o = adr_w - region1_base_i;
    assign hit0     = r0_off_o < R0_BYTES;
    assign hit1     = !hit0 && (r1_off_o < R1_BYTES); // Region 0 wins overlaps
    assign req      = wb_cyc_i && wb_stb_i;

    // Strobe to the hit region only
    assign r0_stb_o = req && hit0;
    assign r1_stb_o = req && hit1;

    // Write payload fans out to both
    assign r0_we_o  = wb_we_i;
    assign r0_dat_o = wb_dat_i;
    assign r0_sel_o = wb_sel_i;
    assign r1_we_o  = wb_we_i;
    assign r1_dat_o = wb_dat_i;
    assign r1_sel_o = wb_sel_i;

    // ====================
    // Response
    // ====================

    always_comb begin
        wb_ack_o = 1'b0;
        wb_dat_o = r0_dat_i;
        if (hit0) begin
            wb_ack_o = r0_ack_i;
        end else if (hit1) begin
            wb_ack_o = r1_ack_i;
            wb_dat_o = r1_dat_i;
        end
    end

    // Miss answers one cycle after the strobe, once per cycle
    always_ff @(posedge clk) begin
        if (rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req && !hit0 && !hit1 && !err_q;
        end
    end

    assign wb_err_o = err_q;

endmodule

/* hdl/data_region_mem.sv */
`include "mem_subsys_defs.svh"

module data_region_mem
    import mem_subsys_pkg::*;
#(
    parameter int ADDR_W = 10 // Word index width
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stb_i,
    input  logic     we_i,
    input  addr_t    off_i, // Byte offset inside the region
    input  word_t    dat_i,
    input  byte_en_t sel_i,
    output logic     ack_o,
    output word_t    dat_o
);

    word_t             mem [0:(1 << ADDR_W)-1];
    logic [ADDR_W-1:0] idx;
    logic              access; // First cycle of a strobe

    assign idx    = off_i[ADDR_W+1:2];
    assign access = stb_i && !ack_o; // Held strobe after ack is the same access

    // Contents start cleared
    initial begin
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem[i] = '0;
        end
    end

    // Lane writes and registered read
    always_ff @(posedge clk) begin
        if (access) begin
            dat_o <= mem[idx]; // Full word, old value on a write
            if (we_i) begin
                for (int b = 0; b < `BE_W; b++) begin
                    if (sel_i[b]) begin
                        mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // Ack one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst_n) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule

/* hdl/rv_mem_subsys.sv */
`include "mem_subsys_defs.svh"

module rv_mem_subsys
    import mem_subsys_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Fetch ports
    input  addr_t     fetch_addr0_i,
    input  addr_t     fetch_addr1_i,
    input  addr_t     fetch_addr2_i,
    output word_t     instruction0_o,
    output word_t     instruction1_o,
    output word_t     instruction2_o,
    // Program load
    input  logic      prog_we_i,
    input  inst_idx_t prog_idx_i,
    input  word_t     prog_data_i,
    // Data port
    input  logic      data_req_i,
    input  logic      data_we_i,
    input  addr_t     data_addr_i,
    input  byte_en_t  data_be_i,
    input  word_t     data_wdata_i,
    output word_t     data_rdata_o,
    output logic      data_ack_o,
    output logic      data_err_o,
    // Region bases
    input  addr_t     region0_base_i,
    input  addr_t     region1_base_i
);

    // Fetch Wishbone links
    logic      f0_stb, f1_stb, f2_stb;
    inst_idx_t f0_idx, f1_idx, f2_idx;
    logic      f0_ack, f1_ack, f2_ack;
    word_t     f0_dat, f1_dat, f2_dat;

    // Data Wishbone link, adapter to router
    logic      dw_cyc, dw_stb, dw_we, dw_ack, dw_err;
    addr_t     dw_adr;
    word_t     dw_wdat, dw_rdat;
    byte_en_t  dw_sel;

    // Region links
    logic      r0_stb, r0_we, r0_ack;
    addr_t     r0_off;
    word_t     r0_wdat, r0_rdat;
    byte_en_t  r0_sel;
    logic      r1_stb, r1_we, r1_ack;
    addr_t     r1_off;
    word_t     r1_wdat, r1_rdat;
    byte_en_t  r1_sel;

    // ====================
    // Fetch path
    // ====================

    inst_fetch_adapter u_fetch0 (
        .clk(clk), .rst_n(rst_n), .fetch_addr_i(fetch_addr0_i),
        .instruction_o(instruction0_o), .wb_stb_o(f0_stb), .wb_idx_o(f0_idx),
        .wb_ack_i(f0_ack), .wb_dat_i(f0_dat)
    );

    inst_fetch_adapter u_fetch1 (
        .clk(clk), .rst_n(rst_n), .fetch_addr_i(fetch_addr1_i),
        .instruction_o(instruction1_o), .wb_stb_o(f1_stb), .wb_idx_o(f1_idx),
        .wb_ack_i(f1_ack), .wb_dat_i(f1_dat)
    );

    inst_fetch_adapter u_fetch2 (
        .clk(clk), .rst_n(rst_n), .fetch_addr_i(fetch_addr2_i),
        .instruction_o(instruction2_o), .wb_stb_o(f2_stb), .wb_idx_o(f2_idx),
        .wb_ack_i(f2_ack), .wb_dat_i(f2_dat)
    );

    inst_mem_3port u_imem (
        .clk(clk), .rst_n(rst_n),
        .stb0_i(f0_stb), .idx0_i(f0_idx), .ack0_o(f0_ack), .dat0_o(f0_dat),
        .stb1_i(f1_stb), .idx1_i(f1_idx), .ack1_o(f1_ack), .dat1_o(f1_dat),
        .stb2_i(f2_stb), .idx2_i(f2_idx), .ack2_o(f2_ack), .dat2_o(f2_dat),
        .prog_we_i(prog_we_i), .prog_idx_i(prog_idx_i), .prog_data_i(prog_data_i)
    );

    // ====================
    // Data path
    // ====================

    data_bus_adapter u_dbus (
        .clk(clk), .rst_n(rst_n),
        .data_req_i(data_req_i), .data_we_i(data_we_i), .data_addr_i(data_addr_i),
        .data_be_i(data_be_i), .data_wdata_i(data_wdata_i), .data_rdata_o(data_rdata_o),
        .data_ack_o(data_ack_o), .data_err_o(data_err_o),
        .wb_cyc_o(dw_cyc), .wb_stb_o(dw_stb), .wb_we_o(dw_we), .wb_adr_o(dw_adr),
        .wb_dat_o(dw_wdat), .wb_sel_o(dw_sel), .wb_ack_i(dw_ack), .wb_err_i(dw_err),
        .wb_dat_i(dw_rdat)
    );

    data_region_router u_router (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc_i(dw_cyc), .wb_stb_i(dw_stb), .wb_we_i(dw_we), .wb_adr_i(dw_adr),
        .wb_dat_i(dw_wdat), .wb_sel_i(dw_sel), .wb_ack_o(dw_ack), .wb_err_o(dw_err),
        .wb_dat_o(dw_rdat),
        .region0_base_i(region0_base_i), .region1_base_i(region1_base_i),
        .r0_stb_o(r0_stb), .r0_we_o(r0_we), .r0_off_o(r0_off), .r0_dat_o(r0_wdat),
        .r0_sel_o(r0_sel), .r0_ack_i(r0_ack), .r0_dat_i(r0_rdat),
        .r1_stb_o(r1_stb), .r1_we_o(r1_we), .r1_off_o(r1_off), .r1_dat_o(r1_wdat),
        .r1_sel_o(r1_sel), .r1_ack_i(r1_ack), .r1_dat_i(r1_rdat)
    );

    // 4 KB region
    data_region_mem #(.ADDR_W(`REGION0_AW)) u_region0 (
        .clk(clk), .rst_n(rst_n), .stb_i(r0_stb), .we_i(r0_we), .off_i(r0_off),
        .dat_i(r0_wdat), .sel_i(r0_sel), .ack_o(r0_ack), .dat_o(r0_rdat)
    );

    // 64 KB region
    data_region_mem #(.ADDR_W(`REGION1_AW)) u_region1 (
        .clk(clk), .rst_n(rst_n), .stb_i(r1_stb), .we_i(r1_we), .off_i(r1_off),
        .dat_i(r1_wdat), .sel_i(r1_sel), .ack_o(r1_ack), .dat_o(r1_rdat)
    );

endmodule

/* sim/tb_rv_mem_subsys.sv */
`include "mem_subsys_defs.svh"

module tb_rv_mem_subsys
    import mem_subsys_pkg::*;
();

    // ====================
    // Test sizing
    // ====================

    localparam int    CLK_PERIOD   = 8;
    localparam int    DRIVE_DELAY  = 1;   // Inputs change this long after the edge
    localparam int    RESET_CYCLES = 10;
    localparam int    PROG_WRITES  = 64;
    localparam int    FETCH_CYCLES = 400;
    localparam int    REGION_OPS   = 100; // Write and read pairs per region
    localparam int    ERR_OPS      = 40;
    localparam int    DATA_BOUND   = 3;   // Edges from driving a request to its pulse
    localparam int    DATA_OPS     = 4 * REGION_OPS + 32 + ERR_OPS + 3 + 64;
    localparam int    TIMEOUT_CYCLES = RESET_CYCLES + PROG_WRITES + FETCH_CYCLES + 3
                                     + DATA_OPS * (DATA_BOUND + 2) + 100;
    localparam addr_t REGION0_BASE = 32'h0000_0000;
    localparam addr_t REGION1_BASE = 32'h7FFE_FFF0;
    localparam addr_t R0_BYTES     = 32'h0000_1000; // 4 KB
    localparam addr_t R1_BYTES     = 32'h0001_0000; // 64 KB

    logic      clk;
    logic      rst_n;
    addr_t     fetch_addr [0:2];
    word_t     instruction [0:2];
    logic      prog_we;
    inst_idx_t prog_idx;
    word_t     prog_data;
    logic      data_req;
    logic      data_we;
    addr_t     data_addr;
    byte_en_t  data_be;
    word_t     data_wdata;
    word_t     data_rdata;
    logic      data_ack;
    logic      data_err;

    // Reference model
    word_t inst_model [0:(1 << `INST_MEM_AW)-1];
    word_t r0_model [0:(1 << `REGION0_AW)-1];
    word_t r1_model [0:(1 << `REGION1_AW)-1];

    integer seed = 62277;
    int     error_count = 0;

    rv_mem_subsys dut (
        .clk(clk), .rst_n(rst_n),
        .fetch_addr0_i(fetch_addr[0]), .fetch_addr1_i(fetch_addr[1]),
        .fetch_addr2_i(fetch_addr[2]),
        .instruction0_o(instruction[0]), .instruction1_o(instruction[1]),
        .instruction2_o(instruction[2]),
        .prog_we_i(prog_we), .prog_idx_i(prog_idx), .prog_data_i(prog_data),
        .data_req_i(data_req), .data_we_i(data_we), .data_addr_i(data_addr),
        .data_be_i(data_be), .data_wdata_i(data_wdata), .data_rdata_o(data_rdata),
        .data_ack_o(data_ack), .data_err_o(data_err),
        .region0_base_i(REGION0_BASE), .region1_base_i(REGION1_BASE)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // ====================
    // Helpers
    // ====================

    task automatic stop_with_failure(input string reason);
        error_count++;
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input word_t expected,
                               input word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error: %s expected %h actual %h",
                                        test_name, expected, actual));
        end
    endtask

    // Region of a byte address with 2 for no region
    function automatic int region_of(input addr_t addr);
        addr_t aligned;
        aligned = addr & ~addr_t'(3); // Low bits ignored
        if (aligned >= REGION0_BASE && aligned < REGION0_BASE + R0_BYTES) begin
            return 0;
        end
        if (aligned >= REGION1_BASE && aligned < REGION1_BASE + R1_BYTES) begin
            return 1;
        end
        return 2;
    endfunction

    function automatic int word_index(input addr_t addr, input addr_t base);
        addr_t off;
        off = addr - base;
        return int'(off[31:2]);
    endfunction

    // Byte lanes with a set enable take the new value
    function automatic word_t merge_lanes(input word_t old_word, input word_t new_word,
                                          input byte_en_t be);
        word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // Region 0 uses 32 low words and region 1 the first and last 16 words
    function automatic addr_t region_addr(input int region, input word_t r);
        logic [`REGION1_AW-1:0] r1_idx;
        if (region == 0) begin
            return REGION0_BASE + {25'b0, r[4:0], r[6:5]};
        end
        r1_idx = r[4] ? {10'h3FF, r[3:0]} : {10'h000, r[3:0]}; // Near the 64 KB end
        return REGION1_BASE + {16'b0, r1_idx, r[6:5]};
    endfunction

    // Gap between the regions or above region 1
    function automatic addr_t error_addr(input word_t r);
        if (r[0]) begin
            return 32'h0000_1000 + {4'b0, r[31:4]};
        end
        return {1'b1, r[30:0]};
    endfunction

    // ====================
    // Data access
    // ====================

    task automatic data_access(input string name, input logic we, input addr_t addr,
                               input byte_en_t be, input word_t wdata);
        int    region;
        int    idx;
        int    waited;
        logic  responded;
        word_t expected;
        region   = region_of(addr);
        idx      = 0;
        expected = '0;
        if (region == 0) begin
            idx      = word_index(addr, REGION0_BASE);
            expected = r0_model[idx];
        end else if (region == 1) begin
            idx      = word_index(addr, REGION1_BASE);
            expected = r1_model[idx];
        end
        @(posedge clk);
        #DRIVE_DELAY;
        data_req   = 1'b1; // Held until the pulse
        data_we    = we;
        data_addr  = addr;
        data_be    = be;
        data_wdata = wdata;
        waited     = 0;
        responded  = 1'b0;
        while (!responded && waited < DATA_BOUND) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
            responded = data_ack || data_err;
        end
        if (!responded) begin
            stop_with_failure($sformatf("The data port did not respond to %s at address %h",
                                        name, addr));
        end
        data_req = 1'b0;
        check_value({name, " ack"}, 32'(region != 2), 32'(data_ack));
        check_value({name, " err"}, 32'(region == 2), 32'(data_err));
        if (region != 2 && !we) begin
            check_value({name, " rdata"}, expected, data_rdata);
        end
        if (region == 0 && we) begin
            r0_model[idx] = merge_lanes(expected, wdata, be);
        end else if (region == 1 && we) begin
            r1_model[idx] = merge_lanes(expected, wdata, be);
        end
        // Exactly one pulse per access
        @(posedge clk);
        #DRIVE_DELAY;
        check_value({name, " ack drop"}, 32'd0, 32'(data_ack));
        check_value({name, " err drop"}, 32'd0, 32'(data_err));
    endtask

    task automatic region_ops(input int region);
        word_t r;
        for (int i = 0; i < REGION_OPS; i++) begin
            r = $random(seed);
            data_access($sformatf("region%0d write %0d", region, i), 1'b1,
                        region_addr(region, r), r[10:7], $random(seed));
            r = $random(seed); // Read anywhere in the same word set
            data_access($sformatf("region%0d read %0d", region, i), 1'b0,
                        region_addr(region, r), 4'hF, '0);
        end
    endtask

    task automatic read_back(input int region);
        for (int i = 0; i < 32; i++) begin
            data_access($sformatf("region%0d readback %0d", region, i), 1'b0,
                        region_addr(region, word_t'(i)), 4'hF, '0);
        end
    endtask

    // ====================
    // Fetch path
    // ====================

    // Address driven after edge E shows up after edge E+3
    task automatic fetch_phase(input int cycles);
        inst_idx_t pipe [0:2][0:2]; // Newest first in each port
        word_t     r;
        for (int c = 0; c < cycles + 3; c++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            for (int p = 0; p < 3; p++) begin
                if (c >= 3) begin
                    check_value($sformatf("fetch port %0d", p), inst_model[pipe[p][2]],
                                instruction[p]);
                end
                pipe[p][2]    = pipe[p][1];
                pipe[p][1]    = pipe[p][0];
                r             = $random(seed);
                pipe[p][0]    = r[31] ? {7'b0, r[6:0]} : r[13:0]; // Half hit the program
                fetch_addr[p] = `INST_BASE_ADDR + {16'b0, pipe[p][0], 2'b00};
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        word_t r;
        rst_n      = 1'b1; // Reset is active high
        prog_we    = 1'b0;
        prog_idx   = '0;
        prog_data  = '0;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_be    = '0;
        data_wdata = '0;
        for (int p = 0; p < 3; p++) begin
            fetch_addr[p] = `INST_BASE_ADDR;
        end
        for (int i = 0; i < (1 << `INST_MEM_AW); i++) begin
            inst_model[i] = `RV_NOP; // Unwritten words read as NOP
        end
        for (int i = 0; i < (1 << `REGION0_AW); i++) begin
            r0_model[i] = '0;
        end
        for (int i = 0; i < (1 << `REGION1_AW); i++) begin
            r1_model[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b0;

        // Outputs idle after reset
        @(posedge clk);
        #DRIVE_DELAY;
        for (int p = 0; p < 3; p++) begin
            check_value($sformatf("reset instruction%0d", p), `RV_NOP, instruction[p]);
        end
        check_value("reset data ack", 32'd0, 32'(data_ack));
        check_value("reset data err", 32'd0, 32'(data_err));

        // Program load into the low 128 words
        for (int i = 0; i < PROG_WRITES; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            r         = $random(seed);
            prog_we   = 1'b1;
            prog_idx  = {7'b0, r[6:0]};
            prog_data = $random(seed);
            inst_model[prog_idx] = prog_data;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        prog_we = 1'b0;

        fetch_phase(FETCH_CYCLES);

        region_ops(0);
        region_ops(1);
        read_back(0); // Region 1 traffic must leave region 0 alone

        // Misses must leave both regions unchanged
        data_access("error low edge", 1'b1, 32'h0000_1000, 4'hF, 32'hDEAD_BEEF);
        data_access("error below region1", 1'b0, 32'h7FFE_FFEC, 4'hF, '0);
        data_access("error past region1", 1'b1, 32'h7FFF_FFF0, 4'hF, 32'h1234_5678);
        for (int i = 0; i < ERR_OPS; i++) begin
            r = $random(seed);
            data_access($sformatf("error access %0d", i), r[1], error_addr($random(seed)),
                        r[5:2], $random(seed));
        end
        read_back(0);
        read_back(1);

        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the operation count
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_with_failure("Watchdog timeout because the tests did not finish in time");
    end

endmodule

/* rv_mem_subsys.f */
+incdir+include
hdl/mem_subsys_pkg.sv
hdl/inst_fetch_adapter.sv
hdl/inst_mem_3port.sv
hdl/data_bus_adapter.sv
hdl/data_region_router.sv
hdl/data_region_mem.sv
hdl/rv_mem_subsys.sv
sim/tb_rv_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f rv_mem_subsys.f --top-module tb_rv_mem_subsys \
        -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_rv_mem_subsys)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
